// ==== hdl/cache_geom_pkg.sv ====
package cache_geom_pkg;

	// data path
	// --------------------
	localparam int word_w = 32;        // data word
	localparam int addr_w = 16;        // word address, not byte

	// block and line geometry
	// --------------------
	localparam int block_w = 2;        // four words per block
	localparam int lines   = 8;        // fully associative, any block in any line
	localparam int line_w  = $clog2(lines);

	// tag is the block address
	localparam int tag_w = addr_w - block_w;

	// line memory index {line, word}
	localparam int cache_addr_w = line_w + block_w;

	// word address
	// --------------------
	// flat view goes out on the memory command port
	// field view splits a core address into block tag and word in block
	typedef union packed {
		logic [addr_w-1:0] flat;
		struct packed {
			logic [tag_w-1:0]   tag;     // upper bits select the block
			logic [block_w-1:0] word;    // lower bits select the word
		} field;
	} word_addr_u;

endpackage

// ==== hdl/cache_ctrl_pkg.sv ====
package cache_ctrl_pkg;

	// controller states
	// --------------------
	localparam int state_w = 3;

	localparam logic [state_w-1:0] st_normal       = 3'd0;  // lookup and serve
	localparam logic [state_w-1:0] st_wait_ready   = 3'd1;  // miss, wait to issue block read
	localparam logic [state_w-1:0] st_wait_victim  = 3'd2;  // pick line, check dirty
	localparam logic [state_w-1:0] st_write_buffer = 3'd3;  // stream victim out
	localparam logic [state_w-1:0] st_read_buffer  = 3'd4;  // fill new block in

	// block transfer
	// --------------------
	// index of the final word of a block, transfers stop here
	localparam logic [cache_geom_pkg::block_w-1:0] last_word = '1;

endpackage

// ==== hdl/tag_cam.sv ====
`timescale 1ns/1ps

module tag_cam (
	input  logic                             clock_i,
	input  logic                             resetn_i,

	// lookup
	input  logic [cache_geom_pkg::tag_w-1:0]  lookup_tag_i,

	// tag write on block fill
	input  logic                             write_i,
	input  logic [cache_geom_pkg::line_w-1:0] write_line_i,
	input  logic [cache_geom_pkg::tag_w-1:0]  write_tag_i,

	// victim readout for writeback address
	input  logic [cache_geom_pkg::line_w-1:0] victim_line_i,

	output logic                             hit_o,
	output logic [cache_geom_pkg::line_w-1:0] hit_line_o,
	output logic [cache_geom_pkg::tag_w-1:0]  victim_tag_o
);
	import cache_geom_pkg::*;

	logic [tag_w-1:0] tags [lines];   // one tag per line
	logic [lines-1:0] valid_q;
	logic [lines-1:0] match;          // per line compare result

	// parallel compare
	// --------------------
	for (genvar i = 0; i < lines; i++) begin : g_match
		assign match[i] = valid_q[i] && (tags[i] == lookup_tag_i);
	end

	// a tag lives in one line only, low index wins anyway
	always_comb begin
		hit_o      = |match;
		hit_line_o = '0;
		for (int i = lines - 1; i >= 0; i--) begin
			if (match[i]) begin
				hit_line_o = line_w'(i);
			end
		end
	end

	assign victim_tag_o = tags[victim_line_i];    // old tag, before the fill overwrites it

	// storage
	// --------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			valid_q <= '0;                        // empty cache
		end else if (write_i) begin
			valid_q[write_line_i] <= 1'b1;
		end
	end

	always_ff @(posedge clock_i) begin
		if (write_i) begin
			tags[write_line_i] <= write_tag_i;
		end
	end

endmodule

// ==== hdl/line_data_ram.sv ====
`timescale 1ns/1ps

module line_data_ram (
	input  logic                                   clock_i,
	input  logic                                   write_i,
	input  logic [cache_geom_pkg::cache_addr_w-1:0] addr_i,   // {line, word}
	input  logic [cache_geom_pkg::word_w-1:0]       data_i,
	output logic [cache_geom_pkg::word_w-1:0]       data_o
);
	import cache_geom_pkg::*;

	// lines x four words
	logic [word_w-1:0] mem [2**cache_addr_w];
	logic [word_w-1:0] rd_q;

	// single port
	// --------------------
	always_ff @(posedge clock_i) begin
		if (write_i) begin
			mem[addr_i] <= data_i;
		end
		rd_q <= mem[addr_i];      // old contents on a write cycle
	end

	// read word shows up one cycle after the address
	// feeds core loads and the writeback stream
	assign data_o = rd_q;

endmodule

// ==== hdl/cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl (
	input  logic                                   clock_i,
	input  logic                                   resetn_i,
	input  logic                                   enable_i,      // low freezes sequencing

	// core side
	input  logic                                   core_req_i,
	input  logic                                   core_rw_i,     // 1 means store
	input  cache_geom_pkg::word_addr_u             core_addr_i,
	input  logic [cache_geom_pkg::word_w-1:0]       core_data_i,
	output logic                                   core_done_o,
	output logic                                   core_hit_o,
	output logic [cache_geom_pkg::word_w-1:0]       core_data_o,

	// memory command
	input  logic                                   mem_ready_i,
	output logic                                   mem_req_o,
	output logic                                   mem_rw_o,      // 1 means block write
	output logic [cache_geom_pkg::addr_w-1:0]       mem_addr_o,

	// incoming buffer
	input  logic                                   buffer_read_ready_i,
	input  logic [cache_geom_pkg::word_w-1:0]       buffer_read_data_i,
	output logic                                   buffer_read_ack_o,

	// outgoing buffer
	input  logic                                   buffer_write_ready_i,
	output logic [cache_geom_pkg::word_w-1:0]       buffer_write_data_o,
	output logic                                   buffer_write_ack_o,

	// perf flags
	output logic                                   flag_hit_o,
	output logic                                   flag_miss_o,
	output logic                                   flag_writeback_o,

	// tag store
	input  logic                                   tag_hit_i,
	input  logic [cache_geom_pkg::line_w-1:0]       tag_hit_line_i,
	input  logic [cache_geom_pkg::tag_w-1:0]        victim_tag_i,
	output logic                                   tag_write_o,
	output logic [cache_geom_pkg::line_w-1:0]       tag_write_line_o,
	output logic [cache_geom_pkg::line_w-1:0]       victim_line_o,

	// line memory
	output logic                                   ram_write_o,
	output logic [cache_geom_pkg::cache_addr_w-1:0] ram_addr_o,
	output logic [cache_geom_pkg::word_w-1:0]       ram_data_o,
	input  logic [cache_geom_pkg::word_w-1:0]       ram_data_i
);
	import cache_geom_pkg::*;
	import cache_ctrl_pkg::*;

	// control state
	// --------------------
	logic [state_w-1:0] state_q;
	logic [block_w-1:0] xfer_q;          // word count within block transfer
	logic [lines-1:0]   dirty_q;         // line modified by a store
	logic [line_w-1:0]  victim_ptr_q;    // round robin, next line to replace
	logic [line_w-1:0]  victim_q;        // line being replaced
	logic               req_q;           // saved request awaiting fill
	logic               rw_q;            // saved request type
	logic               wb_pending_q;    // block write command still owed
	logic               done_q;
	logic               load_q;          // load served last cycle
	logic               flag_hit_q;
	logic               flag_miss_q;
	logic               flag_wb_q;

	// payload
	word_addr_u         wb_addr_q;       // victim block address
	logic [word_w-1:0]  load_data_q;     // held load result

	// decode
	logic               active;          // new or saved request present
	logic               store_now;
	logic               serve_hit;
	logic               push_word;       // word into outgoing buffer
	logic               pull_word;       // word out of incoming buffer
	logic               rd_cmd;
	logic               wb_cmd;
	logic [block_w-1:0] wb_rd_word;      // line memory word to prefetch for writeback
	word_addr_u         rd_addr;         // missed block, word zero

	assign active     = core_req_i | req_q;
	assign store_now  = req_q ? rw_q : core_rw_i;
	assign serve_hit  = enable_i && (state_q == st_normal) && active && tag_hit_i;
	assign core_hit_o = active ? tag_hit_i : 1'b1;    // no stall when idle

	assign push_word = enable_i && (state_q == st_write_buffer) && buffer_write_ready_i;
	assign pull_word = enable_i && (state_q == st_read_buffer) && buffer_read_ready_i;

	// commands only go out while memory is ready
	// earlier block write must leave before the next read
	assign rd_cmd = enable_i && (state_q == st_wait_ready) && mem_ready_i && !wb_pending_q;
	assign wb_cmd = enable_i && wb_pending_q && mem_ready_i;

	always_comb begin
		rd_addr            = core_addr_i;
		rd_addr.field.word = '0;              // whole block
	end

	assign mem_req_o  = rd_cmd | wb_cmd;
	assign mem_rw_o   = wb_cmd;
	assign mem_addr_o = wb_pending_q ? wb_addr_q.flat : rd_addr.flat;

	// buffers, handshake in the same cycle as ready
	assign buffer_read_ack_o   = pull_word;
	assign buffer_write_ack_o  = push_word;
	assign buffer_write_data_o = ram_data_i;      // prefetched one cycle earlier

	// tag written with the last fill word
	assign tag_write_o      = pull_word && (xfer_q == last_word);
	assign tag_write_line_o = victim_q;
	assign victim_line_o    = victim_q;

	// line memory port
	// --------------------
	// read is registered so writeback addresses run one word ahead
	assign wb_rd_word = push_word ? xfer_q + 1'b1 : xfer_q;

	always_comb begin
		ram_write_o = 1'b0;
		ram_data_o  = core_data_i;
		case (state_q)
			st_normal: begin
				ram_addr_o  = {tag_hit_line_i, core_addr_i.field.word};
				ram_write_o = serve_hit & store_now;
			end
			st_wait_victim: begin
				ram_addr_o = {victim_ptr_q, {block_w{1'b0}}};   // word 0 ready on entry
			end
			st_write_buffer: begin
				ram_addr_o = {victim_q, wb_rd_word};
			end
			st_read_buffer: begin
				ram_addr_o  = {victim_q, xfer_q};
				ram_write_o = pull_word;
				ram_data_o  = buffer_read_data_i;
			end
			default: begin
				ram_addr_o = {victim_q, xfer_q};
			end
		endcase
	end

	// sequencing
	// --------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q      <= st_normal;
			xfer_q       <= '0;
			dirty_q      <= '0;
			victim_ptr_q <= '0;
			victim_q     <= '0;
			req_q        <= 1'b0;
			rw_q         <= 1'b0;
			wb_pending_q <= 1'b0;
			done_q       <= 1'b1;          // core may issue right away
			load_q       <= 1'b0;
			flag_hit_q   <= 1'b0;
			flag_miss_q  <= 1'b0;
			flag_wb_q    <= 1'b0;
		end else begin
			// strobes default low
			flag_hit_q  <= 1'b0;
			flag_miss_q <= 1'b0;
			flag_wb_q   <= 1'b0;
			load_q      <= 1'b0;

			if (enable_i) begin
				case (state_q)
					st_normal: begin
						if (active && tag_hit_i) begin
							flag_hit_q <= 1'b1;
							done_q     <= 1'b1;   // also ends a miss
							req_q      <= 1'b0;
							load_q     <= !store_now;
							if (store_now) begin
								dirty_q[tag_hit_line_i] <= 1'b1;
							end
						end else if (active) begin
							// stall core, replay after the fill
							flag_miss_q <= 1'b1;
							req_q       <= 1'b1;
							rw_q        <= core_rw_i;
							done_q      <= 1'b0;
							state_q     <= st_wait_ready;
						end
					end

					st_wait_ready: begin
						if (rd_cmd) begin
							state_q <= st_wait_victim;
						end
					end

					st_wait_victim: begin
						victim_q     <= victim_ptr_q;
						victim_ptr_q <= victim_ptr_q + 1'b1;
						if (dirty_q[victim_ptr_q]) begin
							flag_wb_q <= 1'b1;
							state_q   <= st_write_buffer;
						end else begin
							state_q <= st_read_buffer;   // clean, just overwrite
						end
					end

					st_write_buffer: begin
						if (push_word) begin
							xfer_q <= xfer_q + 1'b1;     // wraps to 0 after last word
							if (xfer_q == '0) begin
								wb_pending_q <= 1'b1;    // command may follow first word
							end
							if (xfer_q == last_word) begin
								dirty_q[victim_q] <= 1'b0;
								state_q           <= st_read_buffer;
							end
						end
					end

					st_read_buffer: begin
						if (pull_word) begin
							xfer_q <= xfer_q + 1'b1;
							if (xfer_q == last_word) begin
								state_q <= st_normal;    // saved request hits next
							end
						end
					end

					default: begin
						state_q <= st_normal;
					end
				endcase

				// writeback command, independent of state
				if (wb_cmd) begin
					wb_pending_q <= 1'b0;
				end
			end
		end
	end

	// latched on first pushed word, tag still the old one here
	always_ff @(posedge clock_i) begin
		if (push_word && (xfer_q == '0)) begin
			wb_addr_q.field.tag  <= victim_tag_i;
			wb_addr_q.field.word <= '0;
		end
		if (load_q) begin
			load_data_q <= ram_data_i;
		end
	end

	// outputs
	// --------------------
	assign core_done_o = done_q;
	assign core_data_o = load_q ? ram_data_i : load_data_q;   // valid the cycle after serve

	assign flag_hit_o       = flag_hit_q;
	assign flag_miss_o      = flag_miss_q;
	assign flag_writeback_o = flag_wb_q;

endmodule

// ==== hdl/cache_top.sv ====
`timescale 1ns/1ps

module cache_top (
	input  logic                             clock_i,
	input  logic                             resetn_i,
	input  logic                             enable_i,

	// core, address and store data held while core_done_o is low
	input  logic                             core_req_i,
	input  logic                             core_rw_i,
	input  cache_geom_pkg::word_addr_u       core_addr_i,
	input  logic [cache_geom_pkg::word_w-1:0] core_data_i,
	output logic                             core_done_o,
	output logic                             core_hit_o,
	output logic [cache_geom_pkg::word_w-1:0] core_data_o,

	// memory command
	input  logic                             mem_ready_i,
	output logic                             mem_req_o,
	output logic                             mem_rw_o,
	output logic [cache_geom_pkg::addr_w-1:0] mem_addr_o,

	// memory to cache
	input  logic                             buffer_read_ready_i,
	input  logic [cache_geom_pkg::word_w-1:0] buffer_read_data_i,
	output logic                             buffer_read_ack_o,

	// cache to memory
	input  logic                             buffer_write_ready_i,
	output logic [cache_geom_pkg::word_w-1:0] buffer_write_data_o,
	output logic                             buffer_write_ack_o,

	// perf
	output logic                             flag_hit_o,
	output logic                             flag_miss_o,
	output logic                             flag_writeback_o
);
	import cache_geom_pkg::*;

	// tag store wiring
	logic                    tag_hit;
	logic [line_w-1:0]       tag_hit_line;
	logic [tag_w-1:0]        victim_tag;
	logic                    tag_write;
	logic [line_w-1:0]       tag_write_line;
	logic [line_w-1:0]       victim_line;

	// line memory wiring
	logic                    ram_write;
	logic [cache_addr_w-1:0] ram_addr;
	logic [word_w-1:0]       ram_wdata;
	logic [word_w-1:0]       ram_rdata;

	cache_ctrl cache_ctrl_i (
		.clock_i              (clock_i),
		.resetn_i             (resetn_i),
		.enable_i             (enable_i),
		.core_req_i           (core_req_i),
		.core_rw_i            (core_rw_i),
		.core_addr_i          (core_addr_i),
		.core_data_i          (core_data_i),
		.core_done_o          (core_done_o),
		.core_hit_o           (core_hit_o),
		.core_data_o          (core_data_o),
		.mem_ready_i          (mem_ready_i),
		.mem_req_o            (mem_req_o),
		.mem_rw_o             (mem_rw_o),
		.mem_addr_o           (mem_addr_o),
		.buffer_read_ready_i  (buffer_read_ready_i),
		.buffer_read_data_i   (buffer_read_data_i),
		.buffer_read_ack_o    (buffer_read_ack_o),
		.buffer_write_ready_i (buffer_write_ready_i),
		.buffer_write_data_o  (buffer_write_data_o),
		.buffer_write_ack_o   (buffer_write_ack_o),
		.flag_hit_o           (flag_hit_o),
		.flag_miss_o          (flag_miss_o),
		.flag_writeback_o     (flag_writeback_o),
		.tag_hit_i            (tag_hit),
		.tag_hit_line_i       (tag_hit_line),
		.victim_tag_i         (victim_tag),
		.tag_write_o          (tag_write),
		.tag_write_line_o     (tag_write_line),
		.victim_line_o        (victim_line),
		.ram_write_o          (ram_write),
		.ram_addr_o           (ram_addr),
		.ram_data_o           (ram_wdata),
		.ram_data_i           (ram_rdata)
	);

	// lookup and fill both use the core tag, held during a miss
	tag_cam tag_cam_i (
		.clock_i       (clock_i),
		.resetn_i      (resetn_i),
		.lookup_tag_i  (core_addr_i.field.tag),
		.write_i       (tag_write),
		.write_line_i  (tag_write_line),
		.write_tag_i   (core_addr_i.field.tag),
		.victim_line_i (victim_line),
		.hit_o         (tag_hit),
		.hit_line_o    (tag_hit_line),
		.victim_tag_o  (victim_tag)
	);

	line_data_ram line_data_ram_i (
		.clock_i (clock_i),
		.write_i (ram_write),
		.addr_i  (ram_addr),
		.data_i  (ram_wdata),
		.data_o  (ram_rdata)
	);

endmodule

// ==== verification/tb_memory.svh ====
// backing memory, one copy on the bus side and one for the reference model
logic [word_w-1:0] bus_mem [mem_words];
logic [word_w-1:0] ref_mem [mem_words];

// word buffers between memory and cache
logic [word_w-1:0] read_fifo [$];      // memory to cache
logic [word_w-1:0] write_fifo [$];     // cache to memory
logic [addr_w-1:0] write_cmd [$];      // block write commands seen

// reference cache
// --------------------
logic              ref_valid [lines];
logic              ref_dirty [lines];
logic [tag_w-1:0]  ref_tag [lines];
logic [word_w-1:0] ref_data [lines][blk_words];
int                ref_ptr;            // round robin victim

// expected block writes, one tag and four words per dirty eviction
logic [tag_w-1:0]  exp_tag [$];
logic [word_w-1:0] exp_data [$];

// depends on every address bit
function automatic logic [word_w-1:0] fill_word(input int addr);
	return {addr[15:0] ^ 16'h9e37, addr[15:0]};
endfunction

task automatic clear_memory();
	for (int a = 0; a < mem_words; a++) begin
		bus_mem[a] = fill_word(a);
		ref_mem[a] = fill_word(a);
	end
	for (int l = 0; l < lines; l++) begin
		ref_valid[l] = 1'b0;
		ref_dirty[l] = 1'b0;
	end
	ref_ptr = 0;
endtask

function automatic int find_line(input logic [tag_w-1:0] tag);
	for (int l = 0; l < lines; l++) begin
		if (ref_valid[l] && ref_tag[l] == tag) begin
			return l;
		end
	end
	return -1;                         // not cached
endfunction

// predicts hit, dirty eviction and load data for one access
task automatic ref_access(input logic rw, input word_addr_u addr, input logic [word_w-1:0] wdata,
		output logic hit, output logic wb, output logic [word_w-1:0] rdata);
	int line;
	line = find_line(addr.field.tag);
	hit  = (line >= 0);
	wb   = 1'b0;
	if (!hit) begin
		line    = ref_ptr;
		ref_ptr = (ref_ptr + 1) % lines;
		if (ref_valid[line] && ref_dirty[line]) begin
			wb = 1'b1;
			exp_tag.push_back(ref_tag[line]);
			for (int w = 0; w < blk_words; w++) begin
				exp_data.push_back(ref_data[line][w]);
				ref_mem[{ref_tag[line], block_w'(w)}] = ref_data[line][w];
			end
		end
		for (int w = 0; w < blk_words; w++) begin
			ref_data[line][w] = ref_mem[{addr.field.tag, block_w'(w)}];
		end
		ref_tag[line]   = addr.field.tag;
		ref_valid[line] = 1'b1;
		ref_dirty[line] = 1'b0;
	end
	if (rw) begin
		ref_data[line][addr.field.word] = wdata;
		ref_dirty[line] = 1'b1;
	end
	rdata = ref_data[line][addr.field.word];
	n_hits   += int'(hit);
	n_misses += int'(!hit);
	n_wb     += int'(wb);
endtask

// bus side memory
// --------------------
task automatic drive_memory();
	mem_ready_i          = ($random(seed) % 4) != 0;
	buffer_write_ready_i = ($random(seed) % 3) != 0;
	buffer_read_ready_i  = (read_fifo.size() > 0) && (($random(seed) % 3) != 0);
	buffer_read_data_i   = (read_fifo.size() > 0) ? read_fifo[0] : '0;
endtask

// store a block once both its command and its four words are in
task automatic commit_block();
	logic [addr_w-1:0] addr;
	logic [tag_w-1:0]  tag;
	logic [word_w-1:0] word;
	logic [word_w-1:0] exp;
	logic              have;
	addr = write_cmd.pop_front();
	have = exp_tag.size() > 0;
	if (!have) begin
		report_error($sformatf("block write to %h without a dirty eviction", addr));
	end else begin
		tag = exp_tag.pop_front();
		if (addr !== {tag, {block_w{1'b0}}}) begin
			report_error($sformatf("block write to %h, expected %h", addr, {tag, 2'b00}));
		end
	end
	for (int w = 0; w < blk_words; w++) begin
		word = write_fifo.pop_front();
		bus_mem[{addr[addr_w-1:block_w], block_w'(w)}] = word;
		if (have) begin
			exp = exp_data.pop_front();
			if (word !== exp) begin
				report_error($sformatf("writeback word %0d is %h, expected %h", w, word, exp));
			end
		end
	end
endtask

// what crosses at the coming rising edge
task automatic observe_memory();
	if (mem_req_o === 1'b1) begin
		if (mem_ready_i !== 1'b1) begin
			report_error("mem_req_o while mem_ready_i low");
		end
		if (mem_rw_o) begin
			write_cmd.push_back(mem_addr_o);
		end else begin
			for (int w = 0; w < blk_words; w++) begin
				read_fifo.push_back(bus_mem[{mem_addr_o[addr_w-1:block_w], block_w'(w)}]);
			end
		end
	end
	if (buffer_read_ack_o === 1'b1) begin
		if (!buffer_read_ready_i || read_fifo.size() == 0) begin
			report_error("buffer_read_ack_o without a word ready");
		end else begin
			void'(read_fifo.pop_front());
		end
	end
	if (buffer_write_ack_o === 1'b1) begin
		if (!buffer_write_ready_i) begin
			report_error("buffer_write_ack_o while buffer_write_ready_i low");
		end
		write_fifo.push_back(buffer_write_data_o);
	end
	if (write_cmd.size() > 0 && write_fifo.size() >= blk_words) begin
		commit_block();
	end
endtask

// ==== verification/tb_cache_top.sv ====
`timescale 1ns/1ps

module tb_cache_top;
	import cache_geom_pkg::*;

	localparam int n_ops     = 300;
	localparam int n_blocks  = 24;            // distinct blocks touched
	localparam int blk_words = 2**block_w;
	localparam int mem_words = 2**addr_w;     // whole word address space
	localparam int wait_max  = 400;           // cycles per wait loop

	logic              clock_i = 1'b0;
	logic              resetn_i;
	logic              enable_i;
	logic              core_req_i;
	logic              core_rw_i;
	word_addr_u        core_addr_i;
	logic [word_w-1:0] core_data_i;
	logic              core_done_o;
	logic              core_hit_o;
	logic [word_w-1:0] core_data_o;
	logic              mem_ready_i;
	logic              mem_req_o;
	logic              mem_rw_o;
	logic [addr_w-1:0] mem_addr_o;
	logic              buffer_read_ready_i;
	logic [word_w-1:0] buffer_read_data_i;
	logic              buffer_read_ack_o;
	logic              buffer_write_ready_i;
	logic [word_w-1:0] buffer_write_data_o;
	logic              buffer_write_ack_o;
	logic              flag_hit_o;
	logic              flag_miss_o;
	logic              flag_writeback_o;

	integer seed     = 49;
	int     errors   = 0;
	int     n_hits   = 0;
	int     n_misses = 0;
	int     n_wb     = 0;
	logic   stuck    = 1'b0;              // a wait ran out

	// core traffic drawn before the clock runs
	logic              op_rw   [n_ops];
	word_addr_u        op_addr [n_ops];
	logic [word_w-1:0] op_data [n_ops];

	task automatic report_error(input string msg);
		errors++;
		$display("error %0t ns: %s", $time, msg);
	endtask

	`include "tb_memory.svh"

	cache_top cache_top_i (.*);

	always #50 clock_i = ~clock_i;        // 100 ns period

	// memory side drives on the falling edge and looks once outputs settle
	always @(negedge clock_i) begin
		drive_memory();
		#1;
		observe_memory();
	end

	// --------------------
	task automatic finish_run();
		$display("hits %0d, misses %0d, writebacks %0d, errors %0d",
			n_hits, n_misses, n_wb, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	endtask

	task automatic timed_out(input string what);
		errors++;
		stuck = 1'b1;
		$display("timed out waiting for %s", what);
	endtask

	task automatic check_quiet(input string when);
		if ({mem_req_o, buffer_read_ack_o, buffer_write_ack_o,
				flag_hit_o, flag_miss_o, flag_writeback_o} !== 6'b0) begin
			report_error($sformatf("strobe active %s", when));
		end
	endtask

	task automatic make_ops();
		int blk;
		for (int i = 0; i < n_ops; i++) begin
			blk = {$random(seed)} % n_blocks;
			op_addr[i].field.tag  = tag_w'(blk * 613 + 21);   // spread over tag range
			op_addr[i].field.word = block_w'({$random(seed)} % 4);
			op_rw[i]              = ({$random(seed)} % 5) < 2;   // about 40% stores
			op_data[i]            = $random(seed);
		end
	endtask

	// one request with miss handling and result checks
	task automatic run_access(input int i, input logic freeze);
		logic              exp_hit;
		logic              exp_wb;
		logic              seen_wb;
		logic [word_w-1:0] exp_rd;
		int                cnt;
		ref_access(op_rw[i], op_addr[i], op_data[i], exp_hit, exp_wb, exp_rd);
		@(negedge clock_i);
		core_req_i  = 1'b1;
		core_rw_i   = op_rw[i];
		core_addr_i = op_addr[i];            // held until the next request
		core_data_i = op_data[i];
		#1;
		if (core_hit_o !== exp_hit) begin
			report_error($sformatf("core_hit_o %b for %h, expected %b",
				core_hit_o, op_addr[i].flat, exp_hit));
		end
		@(negedge clock_i);
		core_req_i = 1'b0;
		#1;
		if (flag_hit_o !== exp_hit || flag_miss_o !== !exp_hit) begin
			report_error($sformatf("flags hit %b miss %b for %h, expected hit %b",
				flag_hit_o, flag_miss_o, op_addr[i].flat, exp_hit));
		end
		// a miss stalls the core right after the request edge
		if (core_done_o !== exp_hit) begin
			report_error($sformatf("core_done_o %b after request to %h, expected %b",
				core_done_o, op_addr[i].flat, exp_hit));
		end
		seen_wb = 1'b0;
		if (freeze && !exp_hit) begin
			repeat (6) begin
				@(negedge clock_i);
				enable_i = 1'b0;
				#1;
				check_quiet("while enable_i is low");
			end
			@(negedge clock_i);
			enable_i = 1'b1;
			#1;
		end
		cnt = 0;
		while (core_done_o !== 1'b1 && cnt < wait_max) begin
			@(negedge clock_i);
			#1;
			seen_wb = seen_wb | flag_writeback_o;
			cnt++;
		end
		if (core_done_o !== 1'b1) begin
			timed_out("core_done_o");
		end else begin
			if (seen_wb !== exp_wb) begin
				report_error($sformatf("flag_writeback_o %b for %h, expected %b",
					seen_wb, op_addr[i].flat, exp_wb));
			end
			if (!op_rw[i] && core_data_o !== exp_rd) begin
				report_error($sformatf("load %h got %h, expected %h",
					op_addr[i].flat, core_data_o, exp_rd));
			end
		end
	endtask

	// last writeback may still be owed after core_done_o
	task automatic drain_writes();
		int cnt;
		cnt = 0;
		while ((exp_tag.size() > 0 || write_cmd.size() > 0) && cnt < wait_max) begin
			@(negedge clock_i);
			cnt++;
		end
		if (exp_tag.size() > 0 || write_cmd.size() > 0) begin
			timed_out("the last block write");
		end else if (read_fifo.size() != 0 || write_fifo.size() != 0) begin
			report_error("words left over in a buffer");
		end
	endtask

	// --------------------
	initial begin
		resetn_i             = 1'b0;
		enable_i             = 1'b1;
		core_req_i           = 1'b0;
		core_rw_i            = 1'b0;
		core_addr_i          = '0;
		core_data_i          = '0;
		mem_ready_i          = 1'b0;
		buffer_read_ready_i  = 1'b0;
		buffer_read_data_i   = '0;
		buffer_write_ready_i = 1'b0;
		clear_memory();
		make_ops();

		repeat (10) @(negedge clock_i);     // ten rising edges in reset
		resetn_i = 1'b1;
		#1;
		if (core_done_o !== 1'b1) begin
			report_error("core_done_o not high after reset");
		end
		check_quiet("after reset");

		for (int i = 0; i < n_ops && !stuck; i++) begin
			run_access(i, (i % 23) == 7);   // some misses get frozen
		end
		if (!stuck) begin
			drain_writes();
		end
		finish_run();
	end

endmodule

// ==== list.f ====
+incdir+verification
hdl/cache_geom_pkg.sv
hdl/cache_ctrl_pkg.sv
hdl/tag_cam.sv
hdl/line_data_ram.sv
hdl/cache_ctrl.sv
hdl/cache_top.sv
verification/tb_cache_top.sv

// ==== run.sh ====
#!/bin/sh
# compile the cache testbench with Verilator, run it, then look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -j 0 \
	--top-module tb_cache_top \
	-f list.f \
	-o sim_tb_cache_top

./obj_dir/sim_tb_cache_top > sim.log 2>&1
cat sim.log

if grep -qx "TEST OK" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
